//--- tests/dcache_cases.txt
# R addr way tag data | S addr strb data | B addr strb data (store into full buffer) | C
# L addr size(0 byte, 1 half, 2 word) signed hit data; all fields hex
R 00001040 1 00001 a1b2c3d4
L 00001040 2 0 1 a1b2c3d4
L 00005040 2 0 0 00000000
R 00002084 2 00002 80ff7f01
L 00002084 0 1 1 00000001
L 00002085 0 1 1 0000007f
L 00002086 0 1 1 ffffffff
L 00002087 0 0 1 00000080
L 00002084 1 1 1 00007f01
L 00002086 1 1 1 ffff80ff
L 00002086 1 0 1 000080ff
S 00001040 2 00005500
S 00001040 2 00006600
L 00001040 2 0 1 a1b266d4
S 00003000 f 12345678
L 00003000 2 0 1 12345678
C
C
L 00001040 2 0 1 a1b266d4
C
L 00003000 2 0 0 00000000
S 00002084 1 000000aa
S 00002084 2 0000bb00
S 00002084 4 00cc0000
S 00002084 8 dd000000
B 00001044 f 0badf00d
L 00002084 2 0 1 ddccbbaa
C
C
C
C
L 00002084 2 0 1 ddccbbaa
L 00001044 2 0 1 0badf00d
L 00001042 1 1 1 ffffa1b2

//--- files.f
+incdir+src
src/dcache_pkg.sv
src/sb_if.sv
src/dpsram.sv
src/store_buffer.sv
src/load_align.sv
src/store_drain.sv
src/dcache.sv
src/dcache_top.sv
tests/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then judge the result from the log

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_dcache -f files.f -o tb_dcache \
    && ./obj_dir/tb_dcache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation reported failures"; exit 1; }
grep -q "All checks passed" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"

//--- tests/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int unsigned CYCLES_PER_CASE = 50;
    // a drain or refill write lands two edges after its pulse
    localparam int unsigned WRITE_SETTLE    = 3;
    localparam int unsigned SET_W           = $clog2(`DC_SET_NUM);

    // one line of the case file
    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
    } case_rec_t;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid_i;
    logic                   req_ready_o;
    logic [31:0]            req_addr_i;
    mem_size_e              req_size_i;
    logic                   req_signed_i;
    logic                   req_store_i;
    logic [3:0]             req_strb_i;
    logic [31:0]            req_wdata_i;
    logic                   resp_valid_o;
    logic                   resp_ready_i;
    logic [31:0]            resp_rdata_o;
    logic                   resp_hit_o;
    logic                   resp_store_o;
    logic                   commit_store_i;
    logic                   refill_valid_i;
    logic [31:0]            refill_addr_i;
    logic [`DC_WAY_NUM-1:0] refill_way_i;
    logic [`DC_TAG_W-1:0]   refill_tag_i;
    logic [31:0]            refill_data_i;

    case_rec_t   recs[$];
    bit          loaded;
    int          errors;
    int          n_checks;
    logic [31:0] got_rdata;
    logic        got_hit;
    logic        got_store;

    // tags placed by refill records, per set and way
    logic [`DC_TAG_W-1:0] filled_tag [`DC_SET_NUM][`DC_WAY_NUM];
    bit                   filled     [`DC_SET_NUM][`DC_WAY_NUM];

    dcache_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_addr_i    (req_addr_i),
        .req_size_i    (req_size_i),
        .req_signed_i  (req_signed_i),
        .req_store_i   (req_store_i),
        .req_strb_i    (req_strb_i),
        .req_wdata_i   (req_wdata_i),
        .resp_valid_o  (resp_valid_o),
        .resp_ready_i  (resp_ready_i),
        .resp_rdata_o  (resp_rdata_o),
        .resp_hit_o    (resp_hit_o),
        .resp_store_o  (resp_store_o),
        .commit_store_i(commit_store_i),
        .refill_valid_i(refill_valid_i),
        .refill_addr_i (refill_addr_i),
        .refill_way_i  (refill_way_i),
        .refill_tag_i  (refill_tag_i),
        .refill_data_i (refill_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // response ready drops on about a quarter of the cycles
    initial begin
        resp_ready_i <= 1'b0;
        void'($urandom(32'h58ef_4eed));
        forever begin
            @(posedge clk);
            resp_ready_i <= ($urandom % 4) != 0;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic note_refill(input logic [31:0] addr, input logic [`DC_WAY_NUM-1:0] way,
                               input logic [`DC_TAG_W-1:0] tag);
        int set;
        set = int'(addr[`DC_INDEX_LOW +: SET_W]);
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            if (way[w]) begin
                filled[set][w]     = 1'b1;
                filled_tag[set][w] = tag;
            end
        end
    endtask

    // a store hits when some refilled way of its set holds its tag
    function automatic logic store_hits(input logic [31:0] addr);
        int   set;
        logic hit;
        set = int'(addr[`DC_INDEX_LOW +: SET_W]);
        hit = 1'b0;
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            if (filled[set][w] && filled_tag[set][w] == addr[31:32-`DC_TAG_W]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic load_cases();
        int          fd;
        string       line;
        case_rec_t   rec;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("tests/dcache_cases.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open tests/dcache_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
                    a = '0;
                    b = '0;
                    c = '0;
                    d = '0;
                    e = '0;
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                                  a, b, c, d, e));
                    rec = '{op: line[0], a: a, b: b, c: c, d: d, e: e};
                    recs.push_back(rec);
                end
            end
            $fclose(fd);
        end
        if (recs.size() == 0) begin
            $display("error: no records were read from the case file");
            errors++;
        end
    endtask

    // drive a request and hold it until the slot takes it
    task automatic send_req(input logic [31:0] addr, input mem_size_e size,
                            input logic sgn, input logic store,
                            input logic [3:0] strb, input logic [31:0] wdata);
        @(posedge clk);
        req_valid_i  <= 1'b1;
        req_addr_i   <= addr;
        req_size_i   <= size;
        req_signed_i <= sgn;
        req_store_i  <= store;
        req_strb_i   <= strb;
        req_wdata_i  <= wdata;
        do begin
            @(negedge clk);
        end while (!req_ready_o);
        @(posedge clk);
        req_valid_i <= 1'b0;
    endtask

    // handshake completes on the next rising edge
    task automatic wait_resp();
        do begin
            @(negedge clk);
        end while (!(resp_valid_o && resp_ready_i));
        got_rdata = resp_rdata_o;
        got_hit   = resp_hit_o;
        got_store = resp_store_o;
    endtask

    task automatic pulse_commit();
        @(posedge clk);
        commit_store_i <= 1'b1;
        @(posedge clk);
        commit_store_i <= 1'b0;
    endtask

    task automatic do_refill(input logic [31:0] addr, input logic [`DC_WAY_NUM-1:0] way,
                             input logic [`DC_TAG_W-1:0] tag, input logic [31:0] data);
        @(posedge clk);
        refill_valid_i <= 1'b1;
        refill_addr_i  <= addr;
        refill_way_i   <= way;
        refill_tag_i   <= tag;
        refill_data_i  <= data;
        @(posedge clk);
        refill_valid_i <= 1'b0;
    endtask

    task automatic run_case(input int idx, input case_rec_t r);
        string name;
        int    err_before;
        err_before = errors;
        name       = $sformatf("%0d %c %08h", idx, r.op, r.a);
        case (r.op)
            "R": begin
                note_refill(r.a, r.b[`DC_WAY_NUM-1:0], r.c[`DC_TAG_W-1:0]);
                do_refill(r.a, r.b[`DC_WAY_NUM-1:0], r.c[`DC_TAG_W-1:0], r.d);
                repeat (WRITE_SETTLE) @(posedge clk);
            end
            "S": begin
                send_req(r.a, SIZE_WORD, 1'b0, 1'b1, r.b[3:0], r.c);
                wait_resp();
                check_equal({name, " store flag"}, 32'd1, {31'd0, got_store});
                check_equal({name, " store hit"}, {31'd0, store_hits(r.a)}, {31'd0, got_hit});
            end
            "C": begin
                pulse_commit();
                repeat (WRITE_SETTLE) @(posedge clk);
            end
            "L": begin
                send_req(r.a, mem_size_e'(r.b[1:0]), r.c[0], 1'b0, 4'h0, 32'h0);
                wait_resp();
                check_equal({name, " hit"}, r.d, {31'd0, got_hit});
                if (r.d[0]) begin
                    check_equal({name, " data"}, r.e, got_rdata);
                end
                check_equal({name, " store flag"}, 32'd0, {31'd0, got_store});
            end
            "B": begin
                // buffer is full, so the store must sit in the slot
                send_req(r.a, SIZE_WORD, 1'b0, 1'b1, r.b[3:0], r.c);
                repeat (4) begin
                    @(negedge clk);
                    check_equal({name, " resp_valid_o"}, 32'd0, {31'd0, resp_valid_o});
                    check_equal({name, " req_ready_o"}, 32'd0, {31'd0, req_ready_o});
                end
                pulse_commit();
                wait_resp();
                check_equal({name, " store flag"}, 32'd1, {31'd0, got_store});
                check_equal({name, " store hit"}, {31'd0, store_hits(r.a)}, {31'd0, got_hit});
            end
            default: begin
                $display("error: record %0d has an unknown type", idx);
                errors++;
            end
        endcase
        $display("%s: %s", name, (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        req_valid_i    <= 1'b0;
        req_addr_i     <= '0;
        req_size_i     <= SIZE_WORD;
        req_signed_i   <= 1'b0;
        req_store_i    <= 1'b0;
        req_strb_i     <= '0;
        req_wdata_i    <= '0;
        commit_store_i <= 1'b0;
        refill_valid_i <= 1'b0;
        refill_addr_i  <= '0;
        refill_way_i   <= '0;
        refill_tag_i   <= '0;
        refill_data_i  <= '0;
        rst_n          <= 1'b0;
        load_cases();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        foreach (recs[i]) begin
            run_case(i, recs[i]);
        end
        $display("tests: %0d, checks: %0d, errors: %0d", recs.size(), n_checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // budget grows with the number of records
    initial begin
        wait (loaded);
        repeat ((recs.size() + 2) * CYCLES_PER_CASE) @(posedge clk);
        $display("timeout: the run did not finish in time, a handshake never came");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // cpu request
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic [31:0]            req_addr_i,
    input  mem_size_e              req_size_i,
    input  logic                   req_signed_i,
    input  logic                   req_store_i,
    input  logic [3:0]             req_strb_i,
    input  logic [31:0]            req_wdata_i,
    // cpu response
    output logic                   resp_valid_o,
    input  logic                   resp_ready_i,
    output logic [31:0]            resp_rdata_o,
    output logic                   resp_hit_o,
    output logic                   resp_store_o,
    // commit side pulses
    input  logic                   commit_store_i,
    input  logic                   refill_valid_i,
    input  logic [31:0]            refill_addr_i,
    input  logic [`DC_WAY_NUM-1:0] refill_way_i,
    input  logic [`DC_TAG_W-1:0]   refill_tag_i,
    input  logic [31:0]            refill_data_i
);

    sb_if      sb ();
    dc_write_t wr;

    dcache u_dcache (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_size_i  (req_size_i),
        .req_signed_i(req_signed_i),
        .req_store_i (req_store_i),
        .req_strb_i  (req_strb_i),
        .req_wdata_i (req_wdata_i),
        .resp_valid_o(resp_valid_o),
        .resp_ready_i(resp_ready_i),
        .resp_rdata_o(resp_rdata_o),
        .resp_hit_o  (resp_hit_o),
        .resp_store_o(resp_store_o),
        .sb          (sb.cache),
        .wr_i        (wr)
    );

    store_buffer u_store_buffer (
        .clk  (clk),
        .rst_n(rst_n),
        .sb   (sb.buffer)
    );

    store_drain u_store_drain (
        .clk           (clk),
        .rst_n         (rst_n),
        .sb            (sb.drain),
        .commit_store_i(commit_store_i),
        .refill_valid_i(refill_valid_i),
        .refill_addr_i (refill_addr_i),
        .refill_way_i  (refill_way_i),
        .refill_tag_i  (refill_tag_i),
        .refill_data_i (refill_data_i),
        .wr_o          (wr)
    );

endmodule

//--- src/dcache.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  logic [31:0] req_addr_i,
    input  mem_size_e   req_size_i,
    input  logic        req_signed_i,
    input  logic        req_store_i,
    input  logic [3:0]  req_strb_i,
    input  logic [31:0] req_wdata_i,
    output logic        resp_valid_o,
    input  logic        resp_ready_i,
    output logic [31:0] resp_rdata_o,
    output logic        resp_hit_o,
    output logic        resp_store_o,
    sb_if.cache         sb,
    input  dc_write_t   wr_i
);

    localparam int unsigned IDX_W    = $clog2(`DC_SET_NUM);
    localparam int unsigned IDX_HI   = `DC_INDEX_LOW + IDX_W - 1;
    localparam int unsigned TAG_LOW  = 32 - `DC_TAG_W;
    localparam int unsigned WOFF_W   = $clog2(`DC_LINE_WORDS);
    localparam int unsigned WORD_LOW = `DC_INDEX_LOW - WOFF_W;
    localparam int unsigned WADDR_W  = IDX_W + WOFF_W;

    // M1 slot
    logic        m1_valid;
    logic [31:0] m1_addr;
    mem_size_e   m1_size;
    logic        m1_signed;
    logic        m1_store;
    logic [3:0]  m1_strb;
    logic [31:0] m1_wdata;

    logic        accept;
    logic        resp_fire;
    logic [31:0] rd_addr;
    logic        tag_conflict;
    logic        tag_conflict_q;
    logic        data_conflict;
    logic        data_conflict_q;
    logic        load_covered;

    cache_tag_t [`DC_WAY_NUM-1:0]        tag_ans;
    logic [`DC_WAY_NUM-1:0][31:0]        data_ans;
    logic [`DC_WAY_NUM-1:0]              tag_hit;
    logic [31:0]                         hit_word;

    // a store cannot respond until the buffer has room
    assign resp_valid_o = m1_valid & ~(m1_store & ~sb.push_ready);
    assign resp_fire    = resp_valid_o & resp_ready_i;
    assign req_ready_o  = ~m1_valid | resp_fire;
    assign accept       = req_valid_i & req_ready_o;

    // a held slot keeps re-reading its own address
    assign rd_addr = accept ? req_addr_i : m1_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid <= 1'b0;
        end else if (accept) begin
            m1_valid <= 1'b1;
        end else if (resp_fire) begin
            m1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m1_addr   <= req_addr_i;
            m1_size   <= req_size_i;
            m1_signed <= req_signed_i;
            m1_store  <= req_store_i;
            m1_strb   <= req_strb_i;
            m1_wdata  <= req_wdata_i;
        end
    end

    // read and write on the same word: take port 1 result next cycle
    assign tag_conflict  = (rd_addr[IDX_HI:`DC_INDEX_LOW] == wr_i.waddr[WADDR_W-1:WOFF_W]);
    assign data_conflict = (rd_addr[IDX_HI:WORD_LOW] == wr_i.waddr);

    always_ff @(posedge clk) begin
        tag_conflict_q  <= tag_conflict;
        data_conflict_q <= data_conflict;
    end

    for (genvar w = 0; w < `DC_WAY_NUM; w++) begin : g_way
        cache_tag_t  rtag0;
        cache_tag_t  rtag1;
        logic [31:0] rdata0;
        logic [31:0] rdata1;

        assign tag_ans[w]  = tag_conflict_q ? rtag1 : rtag0;
        assign data_ans[w] = data_conflict_q ? rdata1 : rdata0;

        dpsram #(
            .DATA_WIDTH($bits(cache_tag_t)),
            .DATA_DEPTH(`DC_SET_NUM),
            .BYTE_SIZE ($bits(cache_tag_t))
        ) u_tag_sram (
            .clk     (clk),
            .rst_n   (rst_n),
            .addr0_i (rd_addr[IDX_HI:`DC_INDEX_LOW]),
            .en0_i   (~tag_conflict),
            .rdata0_o(rtag0),
            .addr1_i (wr_i.waddr[WADDR_W-1:WOFF_W]),
            .we1_i   (wr_i.way[w] & wr_i.tag_we),
            .wdata1_i(wr_i.tag),
            .rdata1_o(rtag1)
        );

        dpsram #(
            .DATA_WIDTH(32),
            .DATA_DEPTH(`DC_SET_NUM * `DC_LINE_WORDS),
            .BYTE_SIZE (8)
        ) u_data_sram (
            .clk     (clk),
            .rst_n   (rst_n),
            .addr0_i (rd_addr[IDX_HI:WORD_LOW]),
            .en0_i   (~data_conflict),
            .rdata0_o(rdata0),
            .addr1_i (wr_i.waddr),
            .we1_i   ({4{wr_i.way[w]}} & wr_i.strb),
            .wdata1_i(wr_i.data),
            .rdata1_o(rdata1)
        );
    end

    // tag compare, ways are exclusive so an or-merge is enough
    always_comb begin
        tag_hit  = '0;
        hit_word = '0;
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            tag_hit[w] = tag_ans[w].valid && (tag_ans[w].tag == m1_addr[31:TAG_LOW]);
            if (tag_hit[w]) begin
                hit_word = hit_word | data_ans[w];
            end
        end
    end

    load_align u_align (
        .sram_word_i(hit_word),
        .sram_hit_i (|tag_hit),
        .entries_i  (sb.entries),
        .addr_i     (m1_addr),
        .size_i     (m1_size),
        .signed_i   (m1_signed),
        .rdata_o    (resp_rdata_o),
        .covered_o  (load_covered)
    );

    // store enters the buffer when its response is taken
    assign sb.push_valid = m1_valid & m1_store & resp_ready_i;

    always_comb begin
        sb.push_entry.valid = 1'b1;
        sb.push_entry.waddr = m1_addr[31:2];
        sb.push_entry.data  = m1_wdata;
        sb.push_entry.strb  = m1_strb;
        sb.push_entry.way   = tag_hit;
    end

    assign resp_hit_o   = m1_store ? |tag_hit : load_covered;
    assign resp_store_o = m1_store;

endmodule

//--- src/store_drain.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module store_drain import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    sb_if.drain                    sb,
    input  logic                   commit_store_i,
    input  logic                   refill_valid_i,
    input  logic [31:0]            refill_addr_i,
    input  logic [`DC_WAY_NUM-1:0] refill_way_i,
    input  logic [`DC_TAG_W-1:0]   refill_tag_i,
    input  logic [31:0]            refill_data_i,
    output dc_write_t              wr_o
);

    localparam int unsigned CNT_W   = $clog2(`DC_SB_SIZE + 1);
    localparam int unsigned WADDR_W = $clog2(`DC_SET_NUM * `DC_LINE_WORDS);

    logic [CNT_W-1:0]       pending;
    logic                   pop_fire;
    logic [`DC_WAY_NUM-1:0] way_q;
    logic                   tag_we_q;
    logic [WADDR_W-1:0]     waddr_q;
    cache_tag_t             tag_q;
    logic [3:0]             strb_q;
    logic [31:0]            data_q;

    // commits that arrive during a refill wait here
    assign sb.pop_ready = (commit_store_i | (pending != '0)) & ~refill_valid_i;
    assign pop_fire     = sb.pop_valid & sb.pop_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= pending + CNT_W'(commit_store_i) - CNT_W'(pop_fire);
        end
    end

    // refill wins; a popped miss has a zero way and writes nothing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            way_q    <= '0;
            tag_we_q <= 1'b0;
        end else if (refill_valid_i) begin
            way_q    <= refill_way_i;
            tag_we_q <= 1'b1;
        end else if (pop_fire) begin
            way_q    <= sb.pop_entry.way;
            tag_we_q <= 1'b0;
        end else begin
            way_q    <= '0;
            tag_we_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_valid_i) begin
            waddr_q <= refill_addr_i[WADDR_W+1:2];
            tag_q   <= '{valid: 1'b1, tag: refill_tag_i};
            strb_q  <= 4'hf;
            data_q  <= refill_data_i;
        end else if (pop_fire) begin
            waddr_q <= sb.pop_entry.waddr[WADDR_W-1:0];
            strb_q  <= sb.pop_entry.strb;
            data_q  <= sb.pop_entry.data;
        end
    end

    always_comb begin
        wr_o.waddr  = waddr_q;
        wr_o.way    = way_q;
        wr_o.tag_we = tag_we_q;
        wr_o.tag    = tag_q;
        wr_o.strb   = strb_q;
        wr_o.data   = data_q;
    end

endmodule

//--- src/load_align.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module load_align import dcache_pkg::*; (
    input  logic [31:0]                 sram_word_i,
    input  logic                        sram_hit_i,
    input  sb_entry_t [`DC_SB_SIZE-1:0] entries_i,
    input  logic [31:0]                 addr_i,
    input  mem_size_e                   size_i,
    input  logic                        signed_i,
    output logic [31:0]                 rdata_o,
    output logic                        covered_o
);

    logic [31:0] merged;
    logic [3:0]  byte_ok;
    logic [3:0]  need;
    logic [31:0] shifted;

    // entries come oldest first, so a later match overwrites
    always_comb begin
        logic [3:0] fwd;
        merged = sram_word_i;
        fwd    = '0;
        for (int i = 0; i < `DC_SB_SIZE; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (entries_i[i].valid && entries_i[i].strb[j] &&
                    entries_i[i].waddr == addr_i[31:2]) begin
                    merged[8*j +: 8] = entries_i[i].data[8*j +: 8];
                    fwd[j]           = 1'b1;
                end
            end
        end
        byte_ok = fwd | {4{sram_hit_i}};
    end

    // bytes the access actually reads
    always_comb begin
        case (size_i)
            SIZE_BYTE: need = 4'b0001 << addr_i[1:0];
            SIZE_HALF: need = 4'b0011 << {addr_i[1], 1'b0};
            default:   need = 4'b1111;
        endcase
    end

    assign covered_o = &(byte_ok | ~need);

    always_comb begin
        case (size_i)
            SIZE_BYTE: begin
                shifted = merged >> {addr_i[1:0], 3'b000};
                rdata_o = {{24{shifted[7] & signed_i}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                shifted = merged >> {addr_i[1], 4'b0000};
                rdata_o = {{16{shifted[15] & signed_i}}, shifted[15:0]};
            end
            default: begin
                shifted = merged;
                rdata_o = shifted;
            end
        endcase
    end

endmodule

//--- src/store_buffer.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module store_buffer import dcache_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    sb_if.buffer sb
);

    localparam int unsigned PTR_W = $clog2(`DC_SB_SIZE);
    localparam int unsigned CNT_W = $clog2(`DC_SB_SIZE + 1);

    sb_entry_t [`DC_SB_SIZE-1:0] mem;
    logic [PTR_W-1:0]            head;
    logic [PTR_W-1:0]            tail;
    logic [CNT_W-1:0]            count;
    logic                        push_fire;
    logic                        pop_fire;

    assign sb.push_ready = (count != CNT_W'(`DC_SB_SIZE));
    assign sb.pop_valid  = (count != '0);
    assign sb.pop_entry  = mem[head];

    assign push_fire = sb.push_valid & sb.push_ready;
    assign pop_fire  = sb.pop_valid & sb.pop_ready;

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[tail] <= sb.push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_fire) begin
                tail <= tail + 1'b1;
            end
            if (pop_fire) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(push_fire) - CNT_W'(pop_fire);
        end
    end

    // rotate so that index 0 is the oldest store
    // slots past count read as invalid
    always_comb begin
        logic [PTR_W-1:0] idx;
        for (int i = 0; i < `DC_SB_SIZE; i++) begin
            idx                 = head + PTR_W'(i);
            sb.entries[i]       = mem[idx];
            sb.entries[i].valid = mem[idx].valid & (CNT_W'(i) < count);
        end
    end

endmodule

//--- src/dpsram.sv
`timescale 1ns/1ps

module dpsram #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned DATA_DEPTH = 1024,
    parameter int unsigned BYTE_SIZE  = 8,
    localparam int unsigned ADDR_W    = $clog2(DATA_DEPTH),
    localparam int unsigned BE_W      = DATA_WIDTH / BYTE_SIZE
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [ADDR_W-1:0]     addr0_i,
    input  logic                  en0_i,
    output logic [DATA_WIDTH-1:0] rdata0_o,
    input  logic [ADDR_W-1:0]     addr1_i,
    input  logic [BE_W-1:0]       we1_i,
    input  logic [DATA_WIDTH-1:0] wdata1_i,
    output logic [DATA_WIDTH-1:0] rdata1_o
);

    logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];
    logic [DATA_WIDTH-1:0] wr_word;

    // contents start cleared, as block ram does on fpga
    initial begin
        for (int i = 0; i < DATA_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // port 1 word after the byte merge
    always_comb begin
        wr_word = mem[addr1_i];
        for (int b = 0; b < BE_W; b++) begin
            if (we1_i[b]) begin
                wr_word[b*BYTE_SIZE +: BYTE_SIZE] = wdata1_i[b*BYTE_SIZE +: BYTE_SIZE];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|we1_i) begin
            mem[addr1_i] <= wr_word;
        end
    end

    // port 1 reads write-first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata0_o <= '0;
            rdata1_o <= '0;
        end else begin
            if (en0_i) begin
                rdata0_o <= mem[addr0_i];
            end
            rdata1_o <= wr_word;
        end
    end

endmodule

//--- src/sb_if.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

interface sb_if import dcache_pkg::*; ();

    // push from the M1 stage
    logic      push_valid;
    logic      push_ready;
    sb_entry_t push_entry;

    // pop towards the drain stage
    logic      pop_valid;
    logic      pop_ready;
    sb_entry_t pop_entry;

    // all entries, oldest first, for load forwarding
    sb_entry_t [`DC_SB_SIZE-1:0] entries;

    modport cache (output push_valid, push_entry, input push_ready, entries);

    modport buffer (
        input  push_valid, push_entry, pop_ready,
        output push_ready, pop_valid, pop_entry, entries
    );

    modport drain (input pop_valid, pop_entry, output pop_ready);

endinterface

//--- src/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    // access size as carried by the request
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // one tag sram word
    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } cache_tag_t;

    // pending store, data already lane aligned
    typedef struct packed {
        logic                   valid;
        logic [29:0]            waddr;
        logic [31:0]            data;
        logic [3:0]             strb;
        logic [`DC_WAY_NUM-1:0] way;
    } sb_entry_t;

    // write on the second sram port
    // waddr is set index and word offset within a way
    typedef struct packed {
        logic [$clog2(`DC_SET_NUM * `DC_LINE_WORDS)-1:0] waddr;
        logic [`DC_WAY_NUM-1:0]                         way;
        logic                                           tag_we;
        cache_tag_t                                     tag;
        logic [3:0]                                     strb;
        logic [31:0]                                    data;
    } dc_write_t;

endpackage

//--- src/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// two ways of 4 KiB each
`define DC_WAY_NUM    2
`define DC_SET_NUM    256
// words per 16-byte line
`define DC_LINE_WORDS 4

// pending stores held until commit
`define DC_SB_SIZE    4

// tag is addr[31:12], set index starts at bit 4
`define DC_TAG_W      20
`define DC_INDEX_LOW  4

`endif
